//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_ebvc
FILELIST   ?= ebvc_top.f
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- ebvc_datapath.sv
////////////////////
// X, Y, Z and A registers with carry and zero flags.
// Add, subtract, compare, store data and output port.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ebvc_datapath (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ld_en,
	input  ebvc_pkg::alu_op_e   alu_op,
	input  ebvc_pkg::reg_sel_e  dst_sel,
	input  ebvc_pkg::reg_sel_e  src_sel,
	input  logic                src_mem,
	input  logic                port_op,
	input  logic                clear_all,
	input  ebvc_pkg::byte_t     cpu_rdata,
	output ebvc_pkg::byte_t     cpu_wdata,
	output logic                carry,
	output logic                zero,
	output ebvc_pkg::byte_t     port_a,
	output logic                port_strobe
);

	ebvc_pkg::byte_t           rf [4];     // Indexed by reg_sel_e.
	ebvc_pkg::byte_t           acc;
	ebvc_pkg::byte_t           operand;
	logic [ebvc_pkg::DATA_W:0] sum;        // Bit 8 is carry out.
	logic [ebvc_pkg::DATA_W:0] diff;       // Bit 8 is borrow.

	assign acc       = rf[ebvc_pkg::SEL_A];
	assign operand   = src_mem ? cpu_rdata : rf[src_sel];
	assign sum       = {1'b0, acc} + {1'b0, operand};
	assign diff      = {1'b0, acc} - {1'b0, operand};
	assign cpu_wdata = rf[src_sel];         // Store source.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rf          <= '{default: '0};
			carry       <= 1'b0;
			zero        <= 1'b0;
			port_a      <= '0;
			port_strobe <= 1'b0;
		end else begin
			port_strobe <= port_op;         // Aligned with port_a update.
			if (port_op) begin
				// CLO arrives as a clear.
				port_a <= (alu_op == ebvc_pkg::ALU_CLR) ? '0 : rf[src_sel];
			end
			if (clear_all) begin
				rf    <= '{default: '0};    // Run start.
				carry <= 1'b0;
				zero  <= 1'b0;
			end else if (ld_en) begin
				case (alu_op)
					ebvc_pkg::ALU_PASS: rf[dst_sel] <= operand;
					ebvc_pkg::ALU_ADD: begin
						rf[ebvc_pkg::SEL_A] <= sum[ebvc_pkg::DATA_W-1:0];
						carry               <= sum[ebvc_pkg::DATA_W];
						zero                <= (sum[ebvc_pkg::DATA_W-1:0] == '0);
					end
					ebvc_pkg::ALU_SUB: begin
						rf[ebvc_pkg::SEL_A] <= diff[ebvc_pkg::DATA_W-1:0];
						carry               <= diff[ebvc_pkg::DATA_W];  // Operand > A.
						zero                <= (diff[ebvc_pkg::DATA_W-1:0] == '0);
					end
					ebvc_pkg::ALU_CMP: begin
						if (dst_sel == ebvc_pkg::SEL_A) begin
							carry <= (operand >= acc);
							zero  <= (operand == acc);
						end else begin
							carry <= 1'b0;      // CLC.
						end
					end
					ebvc_pkg::ALU_INC: rf[dst_sel] <= rf[dst_sel] + 1'b1;
					ebvc_pkg::ALU_DEC: rf[dst_sel] <= rf[dst_sel] - 1'b1;
					ebvc_pkg::ALU_CLR: rf[dst_sel] <= '0;
					ebvc_pkg::ALU_CLR_ACC: begin
						rf[ebvc_pkg::SEL_A] <= '0;
						carry               <= 1'b0;
						zero                <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- ebvc_mem.sv
////////////////////
// 256-byte memory, registered read.
// CPU port while busy, four-phase host port when idle.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ebvc_mem (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            busy,          // Sequencer owns the array.
	input  ebvc_pkg::addr_t cpu_addr,
	input  logic            cpu_we,
	input  ebvc_pkg::byte_t cpu_wdata,
	output ebvc_pkg::byte_t cpu_rdata,
	input  logic            host_req,
	input  logic            host_we,
	input  ebvc_pkg::addr_t host_addr,
	input  ebvc_pkg::byte_t host_wdata,
	output logic            host_ack,
	output ebvc_pkg::byte_t host_rdata
);

	ebvc_pkg::byte_t mem [ebvc_pkg::MEM_DEPTH];
	logic            host_go;              // Host access this cycle.

	// New request only, and never under a run.
	assign host_go = host_req && !host_ack && !busy;

	// Ack FSM, the ack bit is the state.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_ack <= 1'b0;
		end else if (host_go) begin
			host_ack <= 1'b1;              // Access done, raise ack.
		end else if (host_ack && !host_req) begin
			host_ack <= 1'b0;              // Req dropped, release.
		end
	end

	// Single array port, muxed by ownership.
	always_ff @(posedge clk) begin
		if (busy) begin
			if (cpu_we) begin
				mem[cpu_addr] <= cpu_wdata;    // Store instruction.
			end
			cpu_rdata <= mem[cpu_addr];    // Valid next cycle.
		end else if (host_go) begin
			if (host_we) begin
				mem[host_addr] <= host_wdata;
			end
			host_rdata <= mem[host_addr];  // Old byte on a write.
		end
	end

endmodule

`default_nettype wire

//--- ebvc_pkg.sv
////////////////////
// Shared widths, data types and opcode table.
// Datapath operation, register select and step enums.
////////////////////
`default_nettype none

package ebvc_pkg;

	localparam int DATA_W    = 8;              // Data word.
	localparam int ADDR_W    = 8;              // Address word.
	localparam int MEM_DEPTH = 1 << ADDR_W;    // Unified program and data bytes.

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;

	localparam addr_t RESET_PC = '0;           // Every run starts here.

	// Bits [4:3] of the load and store opcodes give the register.
	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_LDX = 8'h01, OP_LIX = 8'h02, OP_STX = 8'h03,
		OP_LDY = 8'h09, OP_LIY = 8'h0A, OP_STY = 8'h0B,
		OP_LDZ = 8'h11, OP_LIZ = 8'h12, OP_STZ = 8'h13,
		OP_INZ = 8'h15, OP_DEZ = 8'h16, OP_CLZ = 8'h17,
		OP_LDA = 8'h19, OP_LIA = 8'h1A, OP_STA = 8'h1B, OP_CLA = 8'h1C,
		OP_ADX = 8'h21, OP_ADY = 8'h22, OP_ADZ = 8'h23, OP_ADD = 8'h24, OP_ADI = 8'h25,
		OP_SUX = 8'h36, OP_SUY = 8'h37, OP_SUZ = 8'h38, OP_SUB = 8'h39, OP_SUI = 8'h3A,
		OP_JMP = 8'h81, OP_JZS = 8'h82, OP_JZC = 8'h83, OP_JCS = 8'h84, OP_JCC = 8'h85,
		OP_CMP = 8'hC1, OP_CMI = 8'hC2, OP_CPX = 8'hC3, OP_CPY = 8'hC4, OP_CPZ = 8'hC5,
		OP_CLC = 8'hC6,
		OP_CLO = 8'hF9, OP_OTX = 8'hFA, OP_OTY = 8'hFB, OP_OTZ = 8'hFC, OP_OTA = 8'hFD,
		OP_HLT = 8'hFF
	} opcode_e;

	typedef enum logic [1:0] {
		SEL_X,                                 // Index 0.
		SEL_Y,
		SEL_Z,
		SEL_A                                  // Accumulator.
	} reg_sel_e;

	// CMP with a destination other than A only clears carry (CLC).
	typedef enum logic [2:0] {
		ALU_PASS,                              // Load operand.
		ALU_ADD,                               // A + operand, both flags.
		ALU_SUB,                               // A - operand, both flags.
		ALU_CMP,                               // Flags only.
		ALU_INC,
		ALU_DEC,
		ALU_CLR,                               // One register to zero.
		ALU_CLR_ACC                            // A, carry and zero.
	} alu_op_e;

	typedef enum logic [2:0] {
		IDLE,                                  // Host owns memory.
		FETCH,                                 // Opcode address out.
		DECODE,                                // Opcode back, one-byte ops run.
		OPERAND,                               // Operand byte address out.
		READ,                                  // Direct address handling.
		EXEC                                   // Multi-byte ops finish.
	} step_e;

endpackage

`default_nettype wire

//--- ebvc_sequencer.sv
////////////////////
// Program counter, instruction register and step FSM.
// Opcode decode into datapath controls, jump conditions.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ebvc_sequencer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                run,
	input  ebvc_pkg::byte_t     cpu_rdata,
	input  logic                carry,
	input  logic                zero,
	output ebvc_pkg::addr_t     cpu_addr,
	output logic                cpu_we,
	output logic                busy,
	output logic                ld_en,
	output ebvc_pkg::alu_op_e   alu_op,
	output ebvc_pkg::reg_sel_e  dst_sel,
	output ebvc_pkg::reg_sel_e  src_sel,
	output logic                src_mem,
	output logic                port_op,
	output logic                clear_all
);

	ebvc_pkg::step_e   state;
	ebvc_pkg::addr_t   pc;
	ebvc_pkg::opcode_e ir;
	ebvc_pkg::addr_t   oa;             // Direct operand address.
	logic              rd_wait;        // Second READ cycle.
	ebvc_pkg::opcode_e op;             // Opcode being decoded.
	logic              d_op;           // Datapath operation.
	logic              d_imm;
	logic              d_dir;
	logic              d_st;
	logic              d_jmp;
	logic              d_port;
	logic              d_hlt;
	logic              d_taken;
	logic              multi;          // Has an operand byte.

	// Opcode arrives from memory in DECODE, held in ir after.
	assign op = (state == ebvc_pkg::DECODE) ? ebvc_pkg::opcode_e'(cpu_rdata) : ir;

	// Operation and destination.
	always_comb begin
		alu_op  = ebvc_pkg::ALU_PASS;
		dst_sel = ebvc_pkg::SEL_A;
		case (op)
			ebvc_pkg::OP_LDX, ebvc_pkg::OP_LDY, ebvc_pkg::OP_LDZ, ebvc_pkg::OP_LDA,
			ebvc_pkg::OP_LIX, ebvc_pkg::OP_LIY, ebvc_pkg::OP_LIZ, ebvc_pkg::OP_LIA:
				dst_sel = ebvc_pkg::reg_sel_e'(op[4:3]);
			ebvc_pkg::OP_INZ: begin
				alu_op  = ebvc_pkg::ALU_INC;
				dst_sel = ebvc_pkg::SEL_Z;
			end
			ebvc_pkg::OP_DEZ: begin
				alu_op  = ebvc_pkg::ALU_DEC;
				dst_sel = ebvc_pkg::SEL_Z;
			end
			ebvc_pkg::OP_CLZ: begin
				alu_op  = ebvc_pkg::ALU_CLR;
				dst_sel = ebvc_pkg::SEL_Z;
			end
			ebvc_pkg::OP_CLA: alu_op = ebvc_pkg::ALU_CLR_ACC;
			ebvc_pkg::OP_ADX, ebvc_pkg::OP_ADY, ebvc_pkg::OP_ADZ,
			ebvc_pkg::OP_ADD, ebvc_pkg::OP_ADI: alu_op = ebvc_pkg::ALU_ADD;
			ebvc_pkg::OP_SUX, ebvc_pkg::OP_SUY, ebvc_pkg::OP_SUZ,
			ebvc_pkg::OP_SUB, ebvc_pkg::OP_SUI: alu_op = ebvc_pkg::ALU_SUB;
			ebvc_pkg::OP_CPX, ebvc_pkg::OP_CPY, ebvc_pkg::OP_CPZ,
			ebvc_pkg::OP_CMP, ebvc_pkg::OP_CMI: alu_op = ebvc_pkg::ALU_CMP;
			ebvc_pkg::OP_CLC: begin
				alu_op  = ebvc_pkg::ALU_CMP;
				dst_sel = ebvc_pkg::SEL_X;     // Carry-only variant.
			end
			ebvc_pkg::OP_CLO: alu_op = ebvc_pkg::ALU_CLR;
			default: ;
		endcase
	end

	// Instruction class, unknown opcodes fall out as NOP.
	always_comb begin
		d_op   = 1'b0;
		d_imm  = 1'b0;
		d_dir  = 1'b0;
		d_st   = 1'b0;
		d_jmp  = 1'b0;
		d_port = 1'b0;
		d_hlt  = 1'b0;
		case (op)
			ebvc_pkg::OP_LDX, ebvc_pkg::OP_LDY, ebvc_pkg::OP_LDZ, ebvc_pkg::OP_LDA,
			ebvc_pkg::OP_ADD, ebvc_pkg::OP_SUB, ebvc_pkg::OP_CMP: begin
				d_op  = 1'b1;
				d_dir = 1'b1;
			end
			ebvc_pkg::OP_LIX, ebvc_pkg::OP_LIY, ebvc_pkg::OP_LIZ, ebvc_pkg::OP_LIA,
			ebvc_pkg::OP_ADI, ebvc_pkg::OP_SUI, ebvc_pkg::OP_CMI: begin
				d_op  = 1'b1;
				d_imm = 1'b1;
			end
			ebvc_pkg::OP_STX, ebvc_pkg::OP_STY, ebvc_pkg::OP_STZ,
			ebvc_pkg::OP_STA: d_st = 1'b1;
			ebvc_pkg::OP_INZ, ebvc_pkg::OP_DEZ, ebvc_pkg::OP_CLZ, ebvc_pkg::OP_CLA,
			ebvc_pkg::OP_ADX, ebvc_pkg::OP_ADY, ebvc_pkg::OP_ADZ,
			ebvc_pkg::OP_SUX, ebvc_pkg::OP_SUY, ebvc_pkg::OP_SUZ,
			ebvc_pkg::OP_CPX, ebvc_pkg::OP_CPY, ebvc_pkg::OP_CPZ,
			ebvc_pkg::OP_CLC: d_op = 1'b1;
			ebvc_pkg::OP_JMP, ebvc_pkg::OP_JZS, ebvc_pkg::OP_JZC,
			ebvc_pkg::OP_JCS, ebvc_pkg::OP_JCC: d_jmp = 1'b1;
			ebvc_pkg::OP_CLO, ebvc_pkg::OP_OTX, ebvc_pkg::OP_OTY,
			ebvc_pkg::OP_OTZ, ebvc_pkg::OP_OTA: d_port = 1'b1;
			ebvc_pkg::OP_HLT: d_hlt = 1'b1;
			default: ;
		endcase
	end

	// Source register for arithmetic, compare, output and store.
	always_comb begin
		case (op)
			ebvc_pkg::OP_ADX, ebvc_pkg::OP_SUX, ebvc_pkg::OP_CPX,
			ebvc_pkg::OP_OTX, ebvc_pkg::OP_STX: src_sel = ebvc_pkg::SEL_X;
			ebvc_pkg::OP_ADY, ebvc_pkg::OP_SUY, ebvc_pkg::OP_CPY,
			ebvc_pkg::OP_OTY, ebvc_pkg::OP_STY: src_sel = ebvc_pkg::SEL_Y;
			ebvc_pkg::OP_ADZ, ebvc_pkg::OP_SUZ, ebvc_pkg::OP_CPZ,
			ebvc_pkg::OP_OTZ, ebvc_pkg::OP_STZ: src_sel = ebvc_pkg::SEL_Z;
			default: src_sel = ebvc_pkg::SEL_A;
		endcase
	end

	// Jump condition from the flags.
	always_comb begin
		case (op)
			ebvc_pkg::OP_JZS: d_taken = zero;
			ebvc_pkg::OP_JZC: d_taken = !zero;
			ebvc_pkg::OP_JCS: d_taken = carry;
			ebvc_pkg::OP_JCC: d_taken = !carry;
			default: d_taken = 1'b1;       // JMP.
		endcase
	end

	assign multi     = d_imm || d_dir || d_st || d_jmp;
	assign src_mem   = d_imm || d_dir;      // Operand on cpu_rdata in EXEC.
	assign busy      = (state != ebvc_pkg::IDLE);
	assign clear_all = (state == ebvc_pkg::IDLE) && run;
	assign ld_en     = d_op && (((state == ebvc_pkg::DECODE) && !multi) ||
		(state == ebvc_pkg::EXEC));
	assign port_op   = d_port && (state == ebvc_pkg::DECODE);
	assign cpu_we    = d_st && (state == ebvc_pkg::EXEC);
	assign cpu_addr  = (((state == ebvc_pkg::READ) && rd_wait) || cpu_we) ? oa : pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ebvc_pkg::IDLE;
			pc      <= ebvc_pkg::RESET_PC;
			ir      <= ebvc_pkg::OP_NOP;
			rd_wait <= 1'b0;
		end else begin
			case (state)
				ebvc_pkg::IDLE: begin
					if (run) begin
						pc    <= ebvc_pkg::RESET_PC;
						state <= ebvc_pkg::FETCH;
					end
				end
				ebvc_pkg::FETCH: begin
					pc    <= pc + 1'b1;
					state <= ebvc_pkg::DECODE;
				end
				ebvc_pkg::DECODE: begin
					ir <= op;
					if (multi) begin
						state <= ebvc_pkg::OPERAND;
					end else if (d_hlt) begin
						state <= ebvc_pkg::IDLE;   // Busy drops next cycle.
					end else begin
						state <= ebvc_pkg::FETCH;
					end
				end
				ebvc_pkg::OPERAND: begin
					pc    <= pc + 1'b1;        // Also the not-taken skip.
					state <= (d_imm || d_jmp) ? ebvc_pkg::EXEC : ebvc_pkg::READ;
				end
				ebvc_pkg::READ: begin
					if (rd_wait) begin
						rd_wait <= 1'b0;
						state   <= ebvc_pkg::EXEC;
					end else if (d_st) begin
						state <= ebvc_pkg::EXEC;   // Write needs no data read.
					end else begin
						rd_wait <= 1'b1;
					end
				end
				ebvc_pkg::EXEC: begin
					if (d_jmp && d_taken) begin
						pc <= cpu_rdata;
					end
					state <= ebvc_pkg::FETCH;
				end
				default: state <= ebvc_pkg::IDLE;
			endcase
		end
	end

	// Address byte arrives in the first READ cycle.
	always_ff @(posedge clk) begin
		if ((state == ebvc_pkg::READ) && !rd_wait) begin
			oa <= cpu_rdata;
		end
	end

endmodule

`default_nettype wire

//--- ebvc_top.f
ebvc_pkg.sv
ebvc_mem.sv
ebvc_sequencer.sv
ebvc_datapath.sv
ebvc_top.sv
tb_ebvc_asserts.sv
tb_ebvc.sv

//--- ebvc_top.sv
////////////////////
// Top level of the accumulator computer.
// Memory, sequencer and datapath.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ebvc_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            run,            // One-cycle start pulse.
	input  logic            host_req,
	input  logic            host_we,
	input  ebvc_pkg::addr_t host_addr,
	input  ebvc_pkg::byte_t host_wdata,
	output logic            host_ack,
	output ebvc_pkg::byte_t host_rdata,
	output logic            busy,
	output ebvc_pkg::byte_t port_a,
	output logic            port_strobe
);

	ebvc_pkg::addr_t    cpu_addr;
	logic               cpu_we;
	ebvc_pkg::byte_t    cpu_wdata;
	ebvc_pkg::byte_t    cpu_rdata;
	logic               ld_en;
	ebvc_pkg::alu_op_e  alu_op;
	ebvc_pkg::reg_sel_e dst_sel;
	ebvc_pkg::reg_sel_e src_sel;
	logic               src_mem;
	logic               port_op;
	logic               clear_all;
	logic               carry;
	logic               zero;

	ebvc_mem u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.busy       (busy),
		.cpu_addr   (cpu_addr),
		.cpu_we     (cpu_we),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_ack   (host_ack),
		.host_rdata (host_rdata)
	);

	ebvc_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.cpu_rdata (cpu_rdata),
		.carry     (carry),
		.zero      (zero),
		.cpu_addr  (cpu_addr),
		.cpu_we    (cpu_we),
		.busy      (busy),
		.ld_en     (ld_en),
		.alu_op    (alu_op),
		.dst_sel   (dst_sel),
		.src_sel   (src_sel),
		.src_mem   (src_mem),
		.port_op   (port_op),
		.clear_all (clear_all)
	);

	ebvc_datapath u_dp (
		.clk         (clk),
		.rst_n       (rst_n),
		.ld_en       (ld_en),
		.alu_op      (alu_op),
		.dst_sel     (dst_sel),
		.src_sel     (src_sel),
		.src_mem     (src_mem),
		.port_op     (port_op),
		.clear_all   (clear_all),
		.cpu_rdata   (cpu_rdata),
		.cpu_wdata   (cpu_wdata),
		.carry       (carry),
		.zero        (zero),
		.port_a      (port_a),
		.port_strobe (port_strobe)
	);

endmodule

`default_nettype wire

//--- tb_ebvc.sv
////////////////////
// Testbench for the accumulator computer.
// Clock, reset, host driver, program table,
// value checker and watchdog.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ebvc;

	localparam int N_ENTRIES  = 8;                       // Programs in the table.
	localparam int CLK_PERIOD = 100;
	localparam int WD_CYCLES  = (N_ENTRIES + 1) * 400;   // Extra slot for the busy test.

	typedef struct {
		ebvc_pkg::byte_t prog [16];
		int              n_prog;
		ebvc_pkg::byte_t exp [16];                       // Port values in order.
		int              n_exp;
		ebvc_pkg::addr_t pre_addr [2];                   // Data bytes before the run.
		ebvc_pkg::byte_t pre_data [2];
		int              n_pre;
		ebvc_pkg::addr_t rb_addr [2];                    // Bytes to read after the run.
		ebvc_pkg::byte_t rb_data [2];
		int              n_rb;
		int              runs;
	} entry_t;

	logic            clk;
	logic            rst_n;
	logic            run;
	logic            host_req;
	logic            host_we;
	ebvc_pkg::addr_t host_addr;
	ebvc_pkg::byte_t host_wdata;
	logic            host_ack;
	ebvc_pkg::byte_t host_rdata;
	logic            busy;
	ebvc_pkg::byte_t port_a;
	logic            port_strobe;

	entry_t          tbl [N_ENTRIES];
	int              cur;                                // Entry being built.
	logic [31:0]     rng;

	ebvc_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_ack    (host_ack),
		.host_rdata  (host_rdata),
		.busy        (busy),
		.port_a      (port_a),
		.port_strobe (port_strobe)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles.", WD_CYCLES);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function ebvc_pkg::byte_t rnd_byte();
		rng = xorshift(rng);
		return rng[7:0];
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic emit(input ebvc_pkg::byte_t b);
		tbl[cur].prog[tbl[cur].n_prog] = b;              // Next program byte.
		tbl[cur].n_prog++;
	endtask

	task automatic emit_arg(input ebvc_pkg::byte_t op, input ebvc_pkg::byte_t arg);
		emit(op);
		emit(arg);                                       // Immediate, address or target.
	endtask

	task automatic expect_port(input ebvc_pkg::byte_t v);
		tbl[cur].exp[tbl[cur].n_exp] = v;
		tbl[cur].n_exp++;
	endtask

	task automatic add_pre(input ebvc_pkg::addr_t addr, input ebvc_pkg::byte_t data);
		tbl[cur].pre_addr[tbl[cur].n_pre] = addr;
		tbl[cur].pre_data[tbl[cur].n_pre] = data;
		tbl[cur].n_pre++;
	endtask

	task automatic add_readback(input ebvc_pkg::addr_t addr, input ebvc_pkg::byte_t data);
		tbl[cur].rb_addr[tbl[cur].n_rb] = addr;
		tbl[cur].rb_data[tbl[cur].n_rb] = data;
		tbl[cur].n_rb++;
	endtask

	task automatic build_table();
		ebvc_pkg::byte_t p, q, r, x, a, m, s1, s2, n;
		logic            c, z;
		for (int i = 0; i < N_ENTRIES; i++) begin
			tbl[i].n_prog = 0;
			tbl[i].n_exp  = 0;
			tbl[i].n_pre  = 0;
			tbl[i].n_rb   = 0;
			tbl[i].runs   = 1;
		end
		// Immediate loads shown on the port, then CLO.
		cur = 0;
		p = rnd_byte();
		q = rnd_byte();
		r = rnd_byte();
		x = rnd_byte();
		emit_arg(ebvc_pkg::OP_LIX, p);
		emit_arg(ebvc_pkg::OP_LIY, q);
		emit_arg(ebvc_pkg::OP_LIZ, r);
		emit_arg(ebvc_pkg::OP_LIA, x);
		emit(ebvc_pkg::OP_OTX);
		emit(ebvc_pkg::OP_OTY);
		emit(ebvc_pkg::OP_OTZ);
		emit(ebvc_pkg::OP_OTA);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_HLT);
		expect_port(p);
		expect_port(q);
		expect_port(r);
		expect_port(x);
		expect_port(8'h00);
		// ADI, SUI and the borrow seen by JCS.
		cur = 1;
		p  = rnd_byte();
		q  = rnd_byte();
		r  = rnd_byte();
		s1 = p + q;                                      // Wraps to 8 bits.
		s2 = s1 - r;
		c  = (r > s1);                                   // Borrow rule.
		emit_arg(ebvc_pkg::OP_LIX, 8'h5A);
		emit_arg(ebvc_pkg::OP_LIA, p);
		emit_arg(ebvc_pkg::OP_ADI, q);
		emit(ebvc_pkg::OP_OTA);
		emit_arg(ebvc_pkg::OP_SUI, r);
		emit(ebvc_pkg::OP_OTA);
		emit_arg(ebvc_pkg::OP_JCS, 8'd14);
		emit(ebvc_pkg::OP_OTY);
		emit(ebvc_pkg::OP_HLT);
		emit(ebvc_pkg::OP_OTX);                          // Address 14.
		emit(ebvc_pkg::OP_HLT);
		expect_port(s1);
		expect_port(s2);
		expect_port(c ? 8'h5A : 8'h00);
		// ADX, SUB from memory and the zero flag seen by JZS.
		cur = 2;
		x  = rnd_byte() | 8'h01;                         // Nonzero marker.
		p  = rnd_byte();
		s1 = p + x;
		m  = rnd_byte();
		q  = m[0] ? s1 : rnd_byte();                     // Half the time a zero result.
		s2 = s1 - q;
		z  = (s2 == 8'h00);
		add_pre(8'h40, q);
		emit_arg(ebvc_pkg::OP_LIX, x);
		emit_arg(ebvc_pkg::OP_LIA, p);
		emit(ebvc_pkg::OP_ADX);
		emit_arg(ebvc_pkg::OP_SUB, 8'h40);
		emit(ebvc_pkg::OP_OTA);
		emit_arg(ebvc_pkg::OP_JZS, 8'd12);
		emit(ebvc_pkg::OP_OTY);
		emit(ebvc_pkg::OP_HLT);
		emit(ebvc_pkg::OP_OTX);                          // Address 12.
		emit(ebvc_pkg::OP_HLT);
		expect_port(s2);
		expect_port(z ? x : 8'h00);
		// CPX, a taken jump skips the CLO.
		cur = 3;
		x = rnd_byte();
		a = rnd_byte() | 8'h01;
		m = rnd_byte();
		if (m[0]) x = a;
		c = (x >= a);
		z = (x == a);
		emit_arg(ebvc_pkg::OP_LIX, x);
		emit_arg(ebvc_pkg::OP_LIA, a);
		emit(ebvc_pkg::OP_CPX);
		emit_arg(ebvc_pkg::OP_JCS, 8'd8);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_OTA);                          // Address 8.
		emit_arg(ebvc_pkg::OP_JZS, 8'd12);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_OTA);                          // Address 12.
		emit(ebvc_pkg::OP_HLT);
		if (!c) expect_port(8'h00);
		expect_port(a);
		if (!z) expect_port(8'h00);
		expect_port(a);
		// CMI against an immediate.
		cur = 4;
		a = rnd_byte() | 8'h01;
		m = rnd_byte();
		q = rnd_byte();
		if (q[1]) m = a;
		c = (m >= a);
		z = (m == a);
		emit_arg(ebvc_pkg::OP_LIA, a);
		emit_arg(ebvc_pkg::OP_CMI, m);
		emit_arg(ebvc_pkg::OP_JCS, 8'd7);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_OTA);                          // Address 7.
		emit_arg(ebvc_pkg::OP_JZS, 8'd11);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_OTA);                          // Address 11.
		emit(ebvc_pkg::OP_HLT);
		if (!c) expect_port(8'h00);
		expect_port(a);
		if (!z) expect_port(8'h00);
		expect_port(a);
		// Equal compare sets both flags, CLC drops carry, CLA drops zero.
		cur = 5;
		a = rnd_byte();
		emit_arg(ebvc_pkg::OP_LIA, a);
		emit_arg(ebvc_pkg::OP_CMI, a);
		emit(ebvc_pkg::OP_CLC);
		emit_arg(ebvc_pkg::OP_JCS, 8'd8);
		emit(ebvc_pkg::OP_CLO);
		emit_arg(ebvc_pkg::OP_JZS, 8'd11);               // Address 8.
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_CLA);                          // Address 11.
		emit_arg(ebvc_pkg::OP_JZS, 8'd15);
		emit(ebvc_pkg::OP_CLO);
		emit(ebvc_pkg::OP_HLT);                          // Address 15.
		expect_port(8'h00);
		expect_port(8'h00);
		// Stores read back by the host, LDY from a stored byte.
		cur = 6;
		x = rnd_byte();
		p = rnd_byte();
		add_pre(8'h40, ~x);
		add_pre(8'h41, ~p);
		emit_arg(ebvc_pkg::OP_LIX, x);
		emit_arg(ebvc_pkg::OP_STX, 8'h40);
		emit_arg(ebvc_pkg::OP_LIA, p);
		emit_arg(ebvc_pkg::OP_STA, 8'h41);
		emit_arg(ebvc_pkg::OP_LDY, 8'h40);
		emit(ebvc_pkg::OP_OTY);
		emit(ebvc_pkg::OP_HLT);
		expect_port(x);
		add_readback(8'h40, x);
		add_readback(8'h41, p);
		// Countdown loop, run twice.
		cur = 7;
		n = (rnd_byte() % 8'd5) + 8'd1;
		tbl[cur].runs = 2;
		emit(ebvc_pkg::OP_OTA);
		emit_arg(ebvc_pkg::OP_LIZ, n);
		emit(ebvc_pkg::OP_OTZ);                          // Address 3.
		emit(ebvc_pkg::OP_DEZ);
		emit(ebvc_pkg::OP_CPZ);                          // Zero once Z meets A, still 0.
		emit_arg(ebvc_pkg::OP_JZC, 8'd3);
		emit_arg(ebvc_pkg::OP_LIA, 8'hEE);
		emit(ebvc_pkg::OP_HLT);
		expect_port(8'h00);                              // A cleared at run start.
		for (ebvc_pkg::byte_t v = n; v != 8'h00; v--) expect_port(v);
	endtask

	// One four-phase host access, called 1 ns after an edge.
	task automatic host_access(input logic we, input ebvc_pkg::addr_t addr,
		input ebvc_pkg::byte_t wdata, output ebvc_pkg::byte_t rdata);
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = addr;
		host_wdata = wdata;
		do begin
			@(posedge clk);
			#1;
		end while (!host_ack);
		rdata    = host_rdata;
		host_req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (host_ack);                            // Ack low before the next req.
	endtask

	task automatic pulse_run();
		@(posedge clk);
		#1 run = 1'b1;
		@(posedge clk);
		#1 run = 1'b0;
		check("busy", 32'(busy), 1);
	endtask

	task automatic run_entry(input int e);
		ebvc_pkg::byte_t got [$];
		ebvc_pkg::byte_t rd;
		for (int i = 0; i < tbl[e].n_prog; i++) host_access(1'b1, i[7:0], tbl[e].prog[i], rd);
		for (int i = 0; i < tbl[e].n_pre; i++) begin
			host_access(1'b1, tbl[e].pre_addr[i], tbl[e].pre_data[i], rd);
		end
		for (int k = 0; k < tbl[e].runs; k++) begin
			got.delete();
			pulse_run();
			forever begin
				@(posedge clk);
				#1;
				if (port_strobe) got.push_back(port_a);
				if (!busy) break;                        // HLT reached.
			end
			check("strobe_count", got.size(), tbl[e].n_exp);
			foreach (got[i]) begin
				check($sformatf("port_a[%0d]", i), 32'(got[i]), 32'(tbl[e].exp[i]));
			end
		end
		for (int i = 0; i < tbl[e].n_prog; i++) begin
			host_access(1'b0, i[7:0], 8'h00, rd);
			check($sformatf("host_rdata[%0d]", i), 32'(rd), 32'(tbl[e].prog[i]));
		end
		for (int i = 0; i < tbl[e].n_rb; i++) begin
			host_access(1'b0, tbl[e].rb_addr[i], 8'h00, rd);
			check("host_rdata", 32'(rd), 32'(tbl[e].rb_data[i]));
		end
	endtask

	initial begin
		ebvc_pkg::byte_t rd;
		logic            waited;
		rst_n      = 1'b0;
		run        = 1'b0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		rng        = 32'hbff0;
		waited     = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		check("busy", 32'(busy), 0);
		check("port_strobe", 32'(port_strobe), 0);
		check("host_ack", 32'(host_ack), 0);
		check("port_a", 32'(port_a), 0);
		for (int e = 0; e < N_ENTRIES; e++) run_entry(e);
		// Req raised under a run waits for busy to fall.
		pulse_run();
		host_req  = 1'b1;
		host_we   = 1'b0;
		host_addr = 8'h00;
		do begin
			@(posedge clk);
			#1;
			if (busy) begin
				waited = 1'b1;
				check("host_ack", 32'(host_ack), 0);
			end
		end while (!host_ack);
		rd       = host_rdata;
		host_req = 1'b0;
		while (host_ack) begin
			@(posedge clk);
			#1;
		end
		check("req_waited", 32'(waited), 1);
		check("host_rdata", 32'(rd), 32'(ebvc_pkg::OP_OTA));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_ebvc_asserts.sv
////////////////////
// Bound checks on the host handshake
// and the output strobe.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ebvc_asserts (
	input logic clk,
	input logic rst_n,
	input logic host_req,
	input logic host_ack,
	input logic busy,
	input logic port_strobe
);

	// Ack answers a request only.
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(host_ack) |-> $past(host_req))
		else $error("host_ack rose without host_req");

	// Ack holds until req drops.
	ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(host_ack && host_req) |=> host_ack)
		else $error("host_ack fell while host_req was high");

	strobe_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		port_strobe |-> busy)
		else $error("port_strobe while busy was low");

endmodule

bind ebvc_top tb_ebvc_asserts i_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.host_req    (host_req),
	.host_ack    (host_ack),
	.busy        (busy),
	.port_strobe (port_strobe)
);

`default_nettype wire
